// File: all.f
vmul_pkg.sv
vmul_ctrl.sv
operand_stage.sv
lane_mult.sv
result_pack.sv
vmul.sv
vmul_tb.sv

// File: lane_mult.sv
module lane_mult (
	input  logic                  clk,
	input  logic                  rst,
	input  vmul_pkg::slice_opnd_t opnd,
	input  vmul_pkg::sew_e        sew,
	output vmul_pkg::slice_prod_t prod
);

	localparam int SW       = vmul_pkg::SLICE_WIDTH;
	localparam int LANES_8  = SW / 8;
	localparam int LANES_16 = SW / 16;

	logic [15:0]     p8  [LANES_8];
	logic [31:0]     p16 [LANES_16];
	logic [2*SW-1:0] p32;

	vmul_pkg::slice_prod_t prod_d;

	// each operand gets one extra top bit, sign or zero by its flag
	for (genvar i = 0; i < LANES_8; i++) begin : g_lane8
		logic signed [8:0] a_ext;
		logic signed [8:0] b_ext;

		assign a_ext = {opnd.a_signed & opnd.a[8*i+7], opnd.a[8*i +: 8]};
		assign b_ext = {opnd.b_signed & opnd.b[8*i+7], opnd.b[8*i +: 8]};
		assign p8[i] = a_ext * b_ext;
	end

	for (genvar i = 0; i < LANES_16; i++) begin : g_lane16
		logic signed [16:0] a_ext;
		logic signed [16:0] b_ext;

		assign a_ext  = {opnd.a_signed & opnd.a[16*i+15], opnd.a[16*i +: 16]};
		assign b_ext  = {opnd.b_signed & opnd.b[16*i+15], opnd.b[16*i +: 16]};
		assign p16[i] = a_ext * b_ext;
	end

	logic signed [SW:0] a32_ext;
	logic signed [SW:0] b32_ext;

	assign a32_ext = {opnd.a_signed & opnd.a[SW-1], opnd.a};
	assign b32_ext = {opnd.b_signed & opnd.b[SW-1], opnd.b};
	// only the low 2*SW bits of the product are kept
	assign p32 = a32_ext * b32_ext;

	always_comb begin
		prod_d = '0;
		case (sew)
			vmul_pkg::sew_8: begin
				for (int i = 0; i < LANES_8; i++) begin
					prod_d.p8[i] = p8[i];
				end
			end
			vmul_pkg::sew_16: begin
				for (int i = 0; i < LANES_16; i++) begin
					prod_d.p16[i] = p16[i];
				end
			end
			vmul_pkg::sew_32: begin
				prod_d.p32 = p32;
			end
			default: begin
				prod_d = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod <= '0;
		end else begin
			prod <= prod_d;
		end
	end

endmodule

// File: operand_stage.sv
module operand_stage (
	input  logic                                                clk,
	input  logic                                                rst,
	input  vmul_pkg::vec_t                                      in_vec0,
	input  vmul_pkg::vec_t                                      in_vec1,
	input  vmul_pkg::mul_op_e                                   in_op,
	output vmul_pkg::slice_opnd_t [vmul_pkg::SLICE_COUNT-1:0]   opnd
);

	localparam int SW = vmul_pkg::SLICE_WIDTH;

	logic a_signed;
	logic b_signed;

	// vec0 is a, vec1 is b
	always_comb begin
		case (in_op)
			vmul_pkg::op_mulh: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
			vmul_pkg::op_mulhsu: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
			end
			default: begin
				// mul keeps the same low half either way
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			opnd <= '0;
		end else begin
			for (int i = 0; i < vmul_pkg::SLICE_COUNT; i++) begin
				opnd[i].a        <= in_vec0[i*SW +: SW];
				opnd[i].b        <= in_vec1[i*SW +: SW];
				opnd[i].a_signed <= a_signed;
				opnd[i].b_signed <= b_signed;
			end
		end
	end

endmodule

// File: result_pack.sv
module result_pack (
	input  logic                                              clk,
	input  logic                                              rst,
	input  vmul_pkg::slice_prod_t [vmul_pkg::SLICE_COUNT-1:0] prod,
	input  vmul_pkg::req_t                                    req,
	output vmul_pkg::vec_t                                    out_vec
);

	localparam int SW       = vmul_pkg::SLICE_WIDTH;
	localparam int LANES_8  = SW / 8;
	localparam int LANES_16 = SW / 16;

	logic           take_high;
	vmul_pkg::vec_t vec_d;

	// every kind except mul returns the upper half
	assign take_high = (req.op != vmul_pkg::op_mul);

	always_comb begin
		vec_d = '0;
		case (req.sew)
			vmul_pkg::sew_8: begin
				for (int s = 0; s < vmul_pkg::SLICE_COUNT; s++) begin
					for (int l = 0; l < LANES_8; l++) begin
						vec_d[s*SW + l*8 +: 8] = take_high ? prod[s].p8[l][15:8] :
						                                     prod[s].p8[l][7:0];
					end
				end
			end
			vmul_pkg::sew_16: begin
				for (int s = 0; s < vmul_pkg::SLICE_COUNT; s++) begin
					for (int l = 0; l < LANES_16; l++) begin
						vec_d[s*SW + l*16 +: 16] = take_high ? prod[s].p16[l][31:16] :
						                                       prod[s].p16[l][15:0];
					end
				end
			end
			vmul_pkg::sew_32: begin
				for (int s = 0; s < vmul_pkg::SLICE_COUNT; s++) begin
					vec_d[s*SW +: SW] = take_high ? prod[s].p32[2*SW-1:SW] :
					                                prod[s].p32[SW-1:0];
				end
			end
			default: begin
				vec_d = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_vec <= '0;
		end else begin
			out_vec <= vec_d;
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f all.f --top-module vmul_tb -o vmul_sim

# the log decides the result, the simulator status does not stop the script here
./obj_dir/vmul_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: vmul.sv
module vmul #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  vmul_pkg::vec_t        in_vec0,
	input  vmul_pkg::vec_t        in_vec1,
	input  vmul_pkg::sew_e        in_sew,
	input  vmul_pkg::mul_op_e     in_op,
	input  logic [ADDR_WIDTH-1:0] in_addr,
	output logic                  out_valid,
	output vmul_pkg::vec_t        out_vec,
	output logic [ADDR_WIDTH-1:0] out_addr
);

	vmul_pkg::req_t                                    s1_req;
	vmul_pkg::req_t                                    s2_req;
	vmul_pkg::slice_opnd_t [vmul_pkg::SLICE_COUNT-1:0] opnd;
	vmul_pkg::slice_prod_t [vmul_pkg::SLICE_COUNT-1:0] prod;

	vmul_ctrl #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) i_ctrl (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_sew    (in_sew),
		.in_op     (in_op),
		.in_addr   (in_addr),
		.s1_req    (s1_req),
		.s2_req    (s2_req),
		.out_valid (out_valid),
		.out_addr  (out_addr)
	);

	// stage 1
	operand_stage i_operand_stage (
		.clk     (clk),
		.rst     (rst),
		.in_vec0 (in_vec0),
		.in_vec1 (in_vec1),
		.in_op   (in_op),
		.opnd    (opnd)
	);

	// stage 2, slice 0 is the low 32 bits
	for (genvar i = 0; i < vmul_pkg::SLICE_COUNT; i++) begin : g_slice
		lane_mult i_lane_mult (
			.clk  (clk),
			.rst  (rst),
			.opnd (opnd[i]),
			.sew  (s1_req.sew),
			.prod (prod[i])
		);
	end

	// stage 3
	result_pack i_result_pack (
		.clk     (clk),
		.rst     (rst),
		.prod    (prod),
		.req     (s2_req),
		.out_vec (out_vec)
	);

endmodule

// File: vmul_ctrl.sv
module vmul_ctrl #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	input  vmul_pkg::sew_e           in_sew,
	input  vmul_pkg::mul_op_e        in_op,
	input  logic [ADDR_WIDTH-1:0]    in_addr,
	output vmul_pkg::req_t           s1_req,
	output vmul_pkg::req_t           s2_req,
	output logic                     out_valid,
	output logic [ADDR_WIDTH-1:0]    out_addr
);

	logic                  s1_valid;
	logic                  s2_valid;
	logic [ADDR_WIDTH-1:0] s1_addr;
	logic [ADDR_WIDTH-1:0] s2_addr;

	// s1 lines up with operand_stage, s2 with lane_mult, out with result_pack
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			out_valid <= 1'b0;
			s1_req    <= '0;
			s2_req    <= '0;
			s1_addr   <= '0;
			s2_addr   <= '0;
			out_addr  <= '0;
		end else begin
			s1_valid <= in_valid;
			if (in_valid) begin
				s1_req.sew <= in_sew;
				s1_req.op  <= in_op;
				s1_addr    <= in_addr;
			end else begin
				// idle slot carries no stale width or kind
				s1_req  <= '0;
				s1_addr <= '0;
			end

			s2_valid <= s1_valid;
			s2_req   <= s1_req;
			s2_addr  <= s1_addr;

			out_valid <= s2_valid;
			out_addr  <= s2_addr;
		end
	end

endmodule

// File: vmul_pkg.sv
package vmul_pkg;

	localparam int VEC_WIDTH   = 64;
	localparam int SLICE_WIDTH = 32;
	localparam int SLICE_COUNT = VEC_WIDTH / SLICE_WIDTH;

	typedef logic [VEC_WIDTH-1:0] vec_t;

	// element width, the top code is reserved and gives a zero result
	typedef enum logic [1:0] {
		sew_8    = 2'b00,
		sew_16   = 2'b01,
		sew_32   = 2'b10,
		sew_rsvd = 2'b11
	} sew_e;

	typedef enum logic [1:0] {
		op_mul    = 2'b00,
		op_mulh   = 2'b01,
		op_mulhu  = 2'b10,
		op_mulhsu = 2'b11
	} mul_op_e;

	// request fields carried alongside the data pipeline
	typedef struct packed {
		sew_e    sew;
		mul_op_e op;
	} req_t;

	typedef struct packed {
		logic [SLICE_WIDTH-1:0] a;
		logic [SLICE_WIDTH-1:0] b;
		logic                   a_signed;
		logic                   b_signed;
	} slice_opnd_t;

	// double-width products of one slice, element 0 is the lowest lane
	typedef union packed {
		logic [SLICE_WIDTH/8-1:0][15:0]  p8;
		logic [SLICE_WIDTH/16-1:0][31:0] p16;
		logic [2*SLICE_WIDTH-1:0]        p32;
	} slice_prod_t;

endpackage

// File: vmul_tb.sv
module vmul_tb;

	localparam int AW = 32;

	logic                  clk;
	logic                  rst;
	logic                  in_valid;
	vmul_pkg::vec_t        in_vec0;
	vmul_pkg::vec_t        in_vec1;
	vmul_pkg::sew_e        in_sew;
	vmul_pkg::mul_op_e     in_op;
	logic [AW-1:0]         in_addr;
	logic                  out_valid;
	vmul_pkg::vec_t        out_vec;
	logic [AW-1:0]         out_addr;

	int unsigned    cycle = 0;
	int unsigned    issued = 0;
	int unsigned    checked = 0;
	vmul_pkg::vec_t exp_vec_q[$];
	logic [AW-1:0]  exp_addr_q[$];
	string          name_q[$];
	int unsigned    due_q[$];

	vmul #(
		.ADDR_WIDTH (AW)
	) i_vmul (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_vec0   (in_vec0),
		.in_vec1   (in_vec1),
		.in_sew    (in_sew),
		.in_op     (in_op),
		.in_addr   (in_addr),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.out_addr  (out_addr)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// each lane extends its operands by signedness, multiplies at full width and picks a half
	function automatic vmul_pkg::vec_t ref_mul(input vmul_pkg::vec_t v0, input vmul_pkg::vec_t v1,
			input vmul_pkg::sew_e sew, input vmul_pkg::mul_op_e op);
		int                  w;
		logic                a_sgn;
		logic                b_sgn;
		logic [127:0]        mask;
		logic [127:0]        sh;
		logic signed [127:0] a;
		logic signed [127:0] b;
		logic signed [127:0] p;
		vmul_pkg::vec_t      res;
		res = '0;
		case (sew)
			vmul_pkg::sew_8:  w = 8;
			vmul_pkg::sew_16: w = 16;
			vmul_pkg::sew_32: w = 32;
			default:          w = 0;
		endcase
		if (w == 0) begin
			return res;
		end
		a_sgn = (op == vmul_pkg::op_mulh) || (op == vmul_pkg::op_mulhsu);
		b_sgn = (op == vmul_pkg::op_mulh);
		mask = (128'd1 << w) - 128'd1;
		for (int i = 0; i < 64 / w; i++) begin
			a = signed'(({64'd0, v0} >> (i * w)) & mask);
			b = signed'(({64'd0, v1} >> (i * w)) & mask);
			if (a_sgn && a[w-1]) begin
				a = a - signed'(mask + 128'd1);
			end
			if (b_sgn && b[w-1]) begin
				b = b - signed'(mask + 128'd1);
			end
			p = a * b;
			sh = (op == vmul_pkg::op_mul) ? unsigned'(p) : unsigned'(p >>> w);
			sh = (sh & mask) << (i * w);
			res = res | sh[63:0];
		end
		return res;
	endfunction

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_vec(input string name, input vmul_pkg::vec_t exp,
			input vmul_pkg::vec_t act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [AW-1:0] exp,
			input logic [AW-1:0] act);
		if (exp !== act) begin
			$display("Error %s address: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_cycle(input string name, input int unsigned exp, input int unsigned act);
		if (exp != act) begin
			$display("Error %s result cycle: expected %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	// registered outputs are settled by the falling edge
	always @(negedge clk) begin : compare_results
		string name;
		if (!rst && out_valid) begin
			if (exp_vec_q.size() == 0) begin
				$display("out_valid was high with no request outstanding at cycle %0d", cycle);
				stop_run();
			end else begin
				name = name_q.pop_front();
				check_cycle(name, due_q.pop_front(), cycle);
				check_vec(name, exp_vec_q.pop_front(), out_vec);
				check_addr(name, exp_addr_q.pop_front(), out_addr);
				checked++;
			end
		end
	end

	// starts on a falling edge and returns on the next one
	task automatic issue(input string name, input vmul_pkg::vec_t v0, input vmul_pkg::vec_t v1,
			input vmul_pkg::sew_e sew, input vmul_pkg::mul_op_e op, input logic [AW-1:0] addr);
		in_valid = 1'b1;
		in_vec0  = v0;
		in_vec1  = v1;
		in_sew   = sew;
		in_op    = op;
		in_addr  = addr;
		exp_vec_q.push_back(ref_mul(v0, v1, sew, op));
		exp_addr_q.push_back(addr);
		name_q.push_back(name);
		due_q.push_back(cycle + 3);
		issued++;
		@(negedge clk);
	endtask

	// idle slot with junk on the data inputs
	task automatic idle();
		in_valid = 1'b0;
		in_vec0  = {$urandom, $urandom};
		in_vec1  = {$urandom, $urandom};
		in_sew   = vmul_pkg::sew_e'($urandom_range(0, 3));
		in_op    = vmul_pkg::mul_op_e'($urandom_range(0, 3));
		in_addr  = $urandom;
		@(negedge clk);
	endtask

	task automatic wait_drain(input int limit);
		for (int t = 0; t < limit && exp_vec_q.size() != 0; t++) begin
			idle();
		end
		if (exp_vec_q.size() != 0) begin
			$display("timed out with %0d results still outstanding", exp_vec_q.size());
			stop_run();
		end
	endtask

	function automatic vmul_pkg::vec_t corner(input int k, input vmul_pkg::sew_e sew);
		case (k)
			0:       return '1;
			1:       return (sew == vmul_pkg::sew_8)  ? {8{8'h80}} :
			                (sew == vmul_pkg::sew_16) ? {4{16'h8000}} : {2{32'h8000_0000}};
			default: return '0;
		endcase
	endfunction

	initial begin
		logic [AW-1:0] addr_ctr;
		clk      = 1'b0;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_vec0  = '0;
		in_vec1  = '0;
		in_sew   = vmul_pkg::sew_8;
		in_op    = vmul_pkg::op_mul;
		in_addr  = '0;
		addr_ctr = 32'h100;
		void'($urandom(32'h8f0a_81d4));
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// idle slots must not pass the address through
		for (int i = 0; i < 10; i++) begin
			in_addr = $urandom;
			@(negedge clk);
			check_flag("idle after reset, out_valid", 1'b0, out_valid);
			check_vec("idle after reset", '0, out_vec);
			check_addr("idle after reset", '0, out_addr);
		end

		issue("single request", 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210,
			vmul_pkg::sew_16, vmul_pkg::op_mulhsu, 32'hcafe_0001);
		wait_drain(20);

		for (int s = 0; s < 3; s++) begin
			for (int o = 0; o < 4; o++) begin
				for (int k = 0; k < 9; k++) begin
					issue($sformatf("corner sew %0d op %0d pair %0d", s, o, k),
						corner(k / 3, vmul_pkg::sew_e'(s)), corner(k % 3, vmul_pkg::sew_e'(s)),
						vmul_pkg::sew_e'(s), vmul_pkg::mul_op_e'(o), addr_ctr);
					addr_ctr++;
				end
			end
		end
		wait_drain(20);

		// back to back keeps three requests in flight
		for (int i = 0; i < 400; i++) begin
			issue($sformatf("back to back %0d", i), {$urandom, $urandom}, {$urandom, $urandom},
				vmul_pkg::sew_e'($urandom_range(0, 2)), vmul_pkg::mul_op_e'($urandom_range(0, 3)),
				$urandom);
		end
		wait_drain(20);

		for (int i = 0; i < 100; i++) begin
			issue($sformatf("gapped %0d", i), {$urandom, $urandom}, {$urandom, $urandom},
				vmul_pkg::sew_e'($urandom_range(0, 2)), vmul_pkg::mul_op_e'($urandom_range(0, 3)),
				$urandom);
			repeat ($urandom_range(0, 4)) idle();
		end
		wait_drain(20);

		for (int i = 0; i < 8; i++) begin
			issue($sformatf("reserved width %0d", i), {$urandom, $urandom}, {$urandom, $urandom},
				vmul_pkg::sew_rsvd, vmul_pkg::mul_op_e'(i % 4), $urandom);
		end
		wait_drain(20);

		if (checked == issued && exp_vec_q.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("checked %0d results of %0d requests", checked, issued);
			stop_run();
		end
	end

endmodule
